// ==== cnn_pkg.sv ====
// Convolution slice package with default widths, kernel sizes and shared enum types
package cnn_pkg;

    // ==================================================
    // Data widths
    // ==================================================
    // Unsigned input pixel
    parameter int CNN_I_F_BW = 8;
    // Signed kernel weight
    parameter int CNN_W_BW   = 8;
    // Nine 17-bit signed products fit in 21 bits
    parameter int CNN_AK_BW  = 21;
    // One extra bit for the sum over channels
    parameter int CNN_ACI_BW = 22;
    // Signed bias
    parameter int CNN_B_BW   = 16;
    // Unsigned output feature
    parameter int CNN_O_F_BW = 8;

    // ==================================================
    // Geometry
    // ==================================================
    parameter int CNN_KX     = 3;
    parameter int CNN_KY     = 3;
    parameter int CNN_CI     = 2;
    parameter int CNN_IMG_W  = 8;

    // Window buffer phase
    typedef enum logic {
        WIN_FILL   = 1'b0,
        WIN_STREAM = 1'b1
    } win_state_e;

    // Activation applied before saturation
    typedef enum logic {
        ACT_PASS = 1'b0,
        ACT_RELU = 1'b1
    } act_mode_e;

endpackage

// ==== cnn_window_buf.sv ====
// Window buffer: line memories and a shift window that turn a raster pixel stream into windows
`timescale 1ns/100ps
module cnn_window_buf #(
    parameter int I_F_BW = cnn_pkg::CNN_I_F_BW,
    parameter int KX     = cnn_pkg::CNN_KX,
    parameter int KY     = cnn_pkg::CNN_KY,
    parameter int IMG_W  = cnn_pkg::CNN_IMG_W
) (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      i_pix_valid,
    input  logic [I_F_BW-1:0]         i_pix,
    output logic                      o_win_valid,
    output logic [KX*KY*I_F_BW-1:0]   o_window
);

    localparam int COL_W = $clog2(IMG_W);
    localparam int ROW_W = (KY > 2) ? $clog2(KY) : 1;

    // ==================================================
    // Raster position and buffer state
    // ==================================================
    logic [COL_W-1:0]     r_col;
    logic [ROW_W-1:0]     r_row;
    cnn_pkg::win_state_e  r_state;
    logic                 w_row_end;
    logic                 w_win_fire;

    assign w_row_end  = (r_col == COL_W'(IMG_W - 1));
    assign w_win_fire = i_pix_valid && (r_state == cnn_pkg::WIN_STREAM)
                        && (r_col >= COL_W'(KX - 1));

    // Row count stops once the first KY-1 rows are stored
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_col   <= '0;
            r_row   <= '0;
            r_state <= cnn_pkg::WIN_FILL;
        end else if (i_pix_valid) begin
            if (w_row_end) begin
                r_col <= '0;
                if (r_state == cnn_pkg::WIN_FILL) begin
                    if (r_row == ROW_W'(KY - 2)) begin
                        r_state <= cnn_pkg::WIN_STREAM;
                    end else begin
                        r_row <= r_row + 1'b1;
                    end
                end
            end else begin
                r_col <= r_col + 1'b1;
            end
        end
    end

    // ==================================================
    // Line memories
    // ==================================================
    // line_mem[0] holds the previous row, line_mem[KY-2] the oldest
    logic [I_F_BW-1:0] line_mem [KY-1][IMG_W];
    logic [I_F_BW-1:0] w_new_col [KY];

    always_ff @(posedge clk) begin
        if (i_pix_valid) begin
            line_mem[0][r_col] <= i_pix;
            for (int k = 1; k < KY - 1; k++) begin
                line_mem[k][r_col] <= line_mem[k-1][r_col];
            end
        end
    end

    // Column entering the window, top row first
    always_comb begin
        w_new_col[KY-1] = i_pix;
        for (int k = 0; k < KY - 1; k++) begin
            w_new_col[KY-2-k] = line_mem[k][r_col];
        end
    end

    // ==================================================
    // Shift window
    // ==================================================
    logic [I_F_BW-1:0] r_win [KY][KX];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int ky = 0; ky < KY; ky++) begin
                for (int kx = 0; kx < KX; kx++) begin
                    r_win[ky][kx] <= '0;
                end
            end
        end else if (i_pix_valid) begin
            for (int ky = 0; ky < KY; ky++) begin
                for (int kx = 0; kx < KX - 1; kx++) begin
                    r_win[ky][kx] <= r_win[ky][kx+1];
                end
                r_win[ky][KX-1] <= w_new_col[ky];
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_win_valid <= 1'b0;
        end else begin
            o_win_valid <= w_win_fire;
        end
    end

    // Position ky*KX+kx, top left in the low bits
    genvar gy, gx;
    generate
        for (gy = 0; gy < KY; gy++) begin : gen_win_row
            for (gx = 0; gx < KX; gx++) begin : gen_win_col
                assign o_window[(gy*KX + gx)*I_F_BW +: I_F_BW] = r_win[gy][gx];
            end
        end
    endgenerate

endmodule

// ==== cnn_kernel.sv ====
// Kernel engine: signed multiply of one window by its weights and a two-stage adder tree
`timescale 1ns/100ps
module cnn_kernel #(
    parameter int KX     = cnn_pkg::CNN_KX,
    parameter int KY     = cnn_pkg::CNN_KY,
    parameter int I_F_BW = cnn_pkg::CNN_I_F_BW,
    parameter int W_BW   = cnn_pkg::CNN_W_BW,
    parameter int M_BW   = cnn_pkg::CNN_I_F_BW + cnn_pkg::CNN_W_BW + 1,
    parameter int AK_BW  = cnn_pkg::CNN_AK_BW
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic [KX*KY*W_BW-1:0]      i_cnn_weight,
    input  logic                       i_in_valid,
    input  logic [KX*KY*I_F_BW-1:0]    i_in_fmap,
    output logic                       o_ot_valid,
    output logic signed [AK_BW-1:0]    o_ot_kernel_acc
);

    localparam int TAPS  = KX * KY;
    localparam int PS_BW = M_BW + $clog2(KX);

    logic [1:0]               r_valid;
    logic signed [M_BW-1:0]   w_mul [TAPS];
    logic signed [M_BW-1:0]   r_mul [TAPS];
    logic signed [PS_BW-1:0]  w_row_sum [KY];
    logic signed [PS_BW-1:0]  r_row_sum [KY];
    logic signed [AK_BW-1:0]  w_total;

    // ==================================================
    // Multipliers
    // ==================================================
    // Pixel gets a zero sign bit
    genvar gt;
    generate
        for (gt = 0; gt < TAPS; gt++) begin : gen_mul
            assign w_mul[gt] = $signed({1'b0, i_in_fmap[gt*I_F_BW +: I_F_BW]})
                               * $signed(i_cnn_weight[gt*W_BW +: W_BW]);
        end
    endgenerate

    // ==================================================
    // Adder tree
    // ==================================================
    // One partial sum per window row
    always_comb begin
        for (int ky = 0; ky < KY; ky++) begin
            w_row_sum[ky] = '0;
            for (int kx = 0; kx < KX; kx++) begin
                w_row_sum[ky] = w_row_sum[ky] + PS_BW'(r_mul[ky*KX + kx]);
            end
        end
    end

    always_comb begin
        w_total = '0;
        for (int ky = 0; ky < KY; ky++) begin
            w_total = w_total + AK_BW'(r_row_sum[ky]);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_valid         <= '0;
            o_ot_kernel_acc <= '0;
            for (int t = 0; t < TAPS; t++) begin
                r_mul[t] <= '0;
            end
            for (int ky = 0; ky < KY; ky++) begin
                r_row_sum[ky] <= '0;
            end
        end else begin
            r_valid <= {r_valid[0], i_in_valid};
            if (i_in_valid) begin
                r_mul <= w_mul;
            end
            if (r_valid[0]) begin
                r_row_sum <= w_row_sum;
            end
            // Final sum lands one cycle behind the strobe
            if (r_valid[1]) begin
                o_ot_kernel_acc <= w_total;
            end
        end
    end

    // Early strobe, high after the partial sum edge
    assign o_ot_valid = r_valid[1];

endmodule

// ==== cnn_acc_ci.sv ====
// Channel accumulator: CI kernel engines on one window and the sum of their results
`timescale 1ns/100ps
module cnn_acc_ci #(
    parameter int I_F_BW = cnn_pkg::CNN_I_F_BW,
    parameter int KX     = cnn_pkg::CNN_KX,
    parameter int KY     = cnn_pkg::CNN_KY,
    parameter int W_BW   = cnn_pkg::CNN_W_BW,
    parameter int CI     = cnn_pkg::CNN_CI,
    parameter int AK_BW  = cnn_pkg::CNN_AK_BW,
    parameter int ACI_BW = cnn_pkg::CNN_ACI_BW
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic [CI*KX*KY*W_BW-1:0]      i_cnn_weight,
    input  logic                          i_in_valid,
    input  logic [KX*KY*I_F_BW-1:0]       i_window,
    output logic                          o_ot_valid,
    output logic signed [ACI_BW-1:0]      o_ot_ci_acc
);

    localparam int LATENCY = 4;
    localparam int CH_W_BW = KX * KY * W_BW;

    // ==================================================
    // Valid pipeline
    // ==================================================
    logic [LATENCY-1:0] r_valid;
    logic [CI-1:0]      w_kernel_valid;

    // Stage 2 waits for every kernel strobe
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_valid <= '0;
        end else begin
            r_valid[0] <= i_in_valid;
            r_valid[1] <= r_valid[0];
            r_valid[2] <= r_valid[1] && (&w_kernel_valid);
            r_valid[3] <= r_valid[2];
        end
    end

    // ==================================================
    // Kernel engines
    // ==================================================
    logic signed [AK_BW-1:0] w_kernel_acc [CI];

    genvar gc;
    generate
        for (gc = 0; gc < CI; gc++) begin : gen_kernel
            logic [CH_W_BW-1:0] w_ch_weight;

            // Channel 0 sits in the low bits of the weight bus
            assign w_ch_weight = i_cnn_weight[gc*CH_W_BW +: CH_W_BW];

            cnn_kernel #(
                .KX     (KX),
                .KY     (KY),
                .I_F_BW (I_F_BW),
                .W_BW   (W_BW),
                .M_BW   (I_F_BW + W_BW + 1),
                .AK_BW  (AK_BW)
            ) u_kernel (
                .clk             (clk),
                .reset_n         (reset_n),
                .i_cnn_weight    (w_ch_weight),
                .i_in_valid      (i_in_valid),
                .i_in_fmap       (i_window),
                .o_ot_valid      (w_kernel_valid[gc]),
                .o_ot_kernel_acc (w_kernel_acc[gc])
            );
        end
    endgenerate

    // ==================================================
    // Channel sum
    // ==================================================
    // Same summing path for any CI, so the latency stays at four
    logic signed [ACI_BW-1:0] w_ci_sum;

    always_comb begin
        w_ci_sum = '0;
        for (int c = 0; c < CI; c++) begin
            w_ci_sum = w_ci_sum + {{(ACI_BW - AK_BW){w_kernel_acc[c][AK_BW-1]}},
                                   w_kernel_acc[c]};
        end
    end

    // Kernel sums are stable while stage 2 is high
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_ot_ci_acc <= '0;
        end else if (r_valid[2]) begin
            o_ot_ci_acc <= w_ci_sum;
        end
    end

    assign o_ot_valid = r_valid[LATENCY-1];

endmodule

// ==== cnn_act_out.sv ====
// Output stage: bias add, optional ReLU and saturation to an unsigned feature value
`timescale 1ns/100ps
module cnn_act_out #(
    parameter int ACI_BW = cnn_pkg::CNN_ACI_BW,
    parameter int B_BW   = cnn_pkg::CNN_B_BW,
    parameter int O_F_BW = cnn_pkg::CNN_O_F_BW
) (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      i_in_valid,
    input  logic signed [ACI_BW-1:0]  i_acc,
    input  logic signed [B_BW-1:0]    i_bias,
    input  cnn_pkg::act_mode_e        i_act_mode,
    output logic                      o_fmap_valid,
    output logic [O_F_BW-1:0]         o_fmap
);

    // One guard bit above the wider operand
    localparam int SUM_BW = ((ACI_BW > B_BW) ? ACI_BW : B_BW) + 1;

    logic signed [SUM_BW-1:0] w_sum;
    logic signed [SUM_BW-1:0] w_act;
    logic [O_F_BW-1:0]        w_sat;

    // ==================================================
    // Bias and activation
    // ==================================================
    assign w_sum = {{(SUM_BW - ACI_BW){i_acc[ACI_BW-1]}}, i_acc}
                 + {{(SUM_BW - B_BW){i_bias[B_BW-1]}}, i_bias};

    assign w_act = ((i_act_mode == cnn_pkg::ACT_RELU) && w_sum[SUM_BW-1]) ? '0 : w_sum;

    // Clamp to 0 .. 2^O_F_BW-1, negatives end at 0 in either mode
    always_comb begin
        if (w_act[SUM_BW-1]) begin
            w_sat = '0;
        end else if (|w_act[SUM_BW-2:O_F_BW]) begin
            w_sat = '1;
        end else begin
            w_sat = w_act[O_F_BW-1:0];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_fmap_valid <= 1'b0;
            o_fmap       <= '0;
        end else begin
            o_fmap_valid <= i_in_valid;
            if (i_in_valid) begin
                o_fmap <= w_sat;
            end
        end
    end

endmodule

// ==== cnn_conv_top.sv ====
// Convolution slice top: window buffer, channel accumulator and output stage in a chain
`timescale 1ns/100ps
module cnn_conv_top (
    input  logic                                       clk,
    input  logic                                       reset_n,
    input  logic                                       i_pix_valid,
    input  logic [cnn_pkg::CNN_I_F_BW-1:0]             i_pix,
    input  logic [cnn_pkg::CNN_CI*cnn_pkg::CNN_KX*cnn_pkg::CNN_KY*cnn_pkg::CNN_W_BW-1:0]
                                                       i_cnn_weight,
    input  logic signed [cnn_pkg::CNN_B_BW-1:0]        i_bias,
    input  cnn_pkg::act_mode_e                         i_act_mode,
    output logic                                       o_fmap_valid,
    output logic [cnn_pkg::CNN_O_F_BW-1:0]             o_fmap
);

    localparam int I_F_BW = cnn_pkg::CNN_I_F_BW;
    localparam int KX     = cnn_pkg::CNN_KX;
    localparam int KY     = cnn_pkg::CNN_KY;
    localparam int ACI_BW = cnn_pkg::CNN_ACI_BW;

    // ==================================================
    // Stage links
    // ==================================================
    logic                          w_win_valid;
    logic [KX*KY*I_F_BW-1:0]       w_window;
    logic                          w_acc_valid;
    logic signed [ACI_BW-1:0]      w_acc;

    cnn_window_buf #(
        .I_F_BW (I_F_BW),
        .KX     (KX),
        .KY     (KY),
        .IMG_W  (cnn_pkg::CNN_IMG_W)
    ) u_window_buf (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_pix_valid (i_pix_valid),
        .i_pix       (i_pix),
        .o_win_valid (w_win_valid),
        .o_window    (w_window)
    );

    // Four cycles from window to channel sum
    cnn_acc_ci #(
        .I_F_BW (I_F_BW),
        .KX     (KX),
        .KY     (KY),
        .W_BW   (cnn_pkg::CNN_W_BW),
        .CI     (cnn_pkg::CNN_CI),
        .AK_BW  (cnn_pkg::CNN_AK_BW),
        .ACI_BW (ACI_BW)
    ) u_acc_ci (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_cnn_weight (i_cnn_weight),
        .i_in_valid   (w_win_valid),
        .i_window     (w_window),
        .o_ot_valid   (w_acc_valid),
        .o_ot_ci_acc  (w_acc)
    );

    cnn_act_out #(
        .ACI_BW (ACI_BW),
        .B_BW   (cnn_pkg::CNN_B_BW),
        .O_F_BW (cnn_pkg::CNN_O_F_BW)
    ) u_act_out (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_in_valid   (w_acc_valid),
        .i_acc        (w_acc),
        .i_bias       (i_bias),
        .i_act_mode   (i_act_mode),
        .o_fmap_valid (o_fmap_valid),
        .o_fmap       (o_fmap)
    );

endmodule

// ==== tb_cnn_conv.sv ====
// Testbench for the convolution slice: pattern-driven pixel stream with output and latency checks
`timescale 1ns/100ps
module tb_cnn_conv;

    localparam int IMG_W    = cnn_pkg::CNN_IMG_W;
    localparam int N_PIX    = 64;
    localparam int N_OUT    = 36;
    localparam int N_WB     = cnn_pkg::CNN_CI * cnn_pkg::CNN_KX * cnn_pkg::CNN_KY;
    localparam int CASE_LEN = N_WB + 3 + N_PIX + N_OUT;
    localparam int N_CASES  = 3;
    localparam int LATENCY  = 6;

    logic                                   clk;
    logic                                   reset_n;
    logic                                   i_pix_valid;
    logic [cnn_pkg::CNN_I_F_BW-1:0]         i_pix;
    logic [N_WB*cnn_pkg::CNN_W_BW-1:0]      i_cnn_weight;
    logic signed [cnn_pkg::CNN_B_BW-1:0]    i_bias;
    cnn_pkg::act_mode_e                     i_act_mode;
    logic                                   o_fmap_valid;
    logic [cnn_pkg::CNN_O_F_BW-1:0]         o_fmap;

    // Per case: weights, bias high and low byte, mode, pixels, expected outputs
    logic [7:0]  pat_mem [CASE_LEN*N_CASES];
    logic [7:0]  exp_q [$];
    int          due_q [$];
    logic [7:0]  exp_val;
    int          due;
    int          cycle = 0;
    int          n_out;
    int          n_checks;
    int          n_errors;
    bit          check_lat;
    logic [31:0] rng_state;

    cnn_conv_top u_dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_pix_valid  (i_pix_valid),
        .i_pix        (i_pix),
        .i_cnn_weight (i_cnn_weight),
        .i_bias       (i_bias),
        .i_act_mode   (i_act_mode),
        .o_fmap_valid (o_fmap_valid),
        .o_fmap       (o_fmap)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ==================================================
    // Output monitor
    // ==================================================
    // Sampled on the falling edge, half a cycle after the outputs settle
    always @(negedge clk) begin
        if (reset_n && o_fmap_valid) begin
            n_out++;
            if (exp_q.size() == 0) begin
                n_errors++;
                $display("Output 0x%02h arrived with no expected value left", o_fmap);
            end else begin
                exp_val = exp_q.pop_front();
                n_checks++;
                if (o_fmap !== exp_val) begin
                    n_errors++;
                    $display("FAIL o_fmap: expected 0x%02h, got 0x%02h at output %0d",
                             exp_val, o_fmap, n_out - 1);
                end
            end
            if (check_lat) begin
                if (due_q.size() == 0) begin
                    n_errors++;
                    $display("Output at cycle %0d has no completing pixel", cycle);
                end else begin
                    due = due_q.pop_front();
                    n_checks++;
                    if (cycle != due) begin
                        n_errors++;
                        $display("FAIL o_fmap_valid: expected cycle 0x%0h, got 0x%0h",
                                 due, cycle);
                    end
                end
            end
        end
    end

    // ==================================================
    // Stimulus tasks
    // ==================================================
    task automatic apply_reset();
        reset_n     = 1'b0;
        i_pix_valid = 1'b0;
        exp_q.delete();
        due_q.delete();
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;
    endtask

    task automatic load_case(input int idx, input bit force_pass);
        int base;
        base = idx * CASE_LEN;
        for (int i = 0; i < N_WB; i++) begin
            i_cnn_weight[i*8 +: 8] = pat_mem[base + i];
        end
        i_bias = {pat_mem[base + N_WB], pat_mem[base + N_WB + 1]};
        if (force_pass) begin
            i_act_mode = cnn_pkg::ACT_PASS;
        end else begin
            i_act_mode = cnn_pkg::act_mode_e'(pat_mem[base + N_WB + 2][0]);
        end
        exp_q.delete();
        for (int i = 0; i < N_OUT; i++) begin
            exp_q.push_back(pat_mem[base + N_WB + 3 + N_PIX + i]);
        end
        n_out = 0;
    endtask

    // Random idle cycles only when gaps is set
    task automatic stream_pixels(input int idx, input int n_pix, input bit gaps);
        int base;
        int n_idle;
        int row;
        int col;
        base = idx * CASE_LEN + N_WB + 3;
        for (int p = 0; p < n_pix; p++) begin
            n_idle = 0;
            if (gaps) begin
                rng_state = xorshift32(rng_state);
                n_idle    = rng_state[2] ? 0 : int'(rng_state[1:0]);
            end
            repeat (n_idle) begin
                @(posedge clk);
                #1;
                i_pix_valid = 1'b0;
            end
            @(posedge clk);
            #1;
            i_pix_valid = 1'b1;
            i_pix       = pat_mem[base + p];
            row         = p / IMG_W;
            col         = p % IMG_W;
            // Pixel completes a window
            if (check_lat && row >= cnn_pkg::CNN_KY - 1 && col >= cnn_pkg::CNN_KX - 1) begin
                due_q.push_back(cycle + LATENCY);
            end
        end
        @(posedge clk);
        #1;
        i_pix_valid = 1'b0;
    endtask

    task automatic wait_drain(input string label);
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < 100) begin
            @(posedge clk);
            t++;
        end
        if (exp_q.size() != 0) begin
            n_errors++;
            $display("Timeout in %s: %0d outputs never appeared", label, exp_q.size());
        end
        // Quiet time so a stray extra output is still caught
        repeat (10) @(posedge clk);
        #1;
        n_checks++;
        if (n_out != N_OUT) begin
            n_errors++;
            $display("Wrong number of outputs in %s: %0d instead of %0d", label, n_out, N_OUT);
        end
    endtask

    task automatic run_case(input int idx, input bit force_pass, input bit gaps,
                            input string label);
        apply_reset();
        load_case(idx, force_pass);
        check_lat = !gaps;
        stream_pixels(idx, N_PIX, gaps);
        wait_drain(label);
    endtask

    task automatic reset_mid_image();
        int t;
        apply_reset();
        load_case(0, 1'b0);
        check_lat = 1'b1;
        stream_pixels(0, 40, 1'b0);
        t = 0;
        while (!o_fmap_valid && t < 20) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (!o_fmap_valid) begin
            n_errors++;
            $display("No output was in flight before the mid-image reset");
        end
        check_lat = 1'b0;
        reset_n   = 1'b0;
        #1;
        n_checks++;
        if (o_fmap_valid !== 1'b0) begin
            n_errors++;
            $display("FAIL o_fmap_valid: expected 0x0, got 0x%0h", o_fmap_valid);
        end
        if (o_fmap !== '0) begin
            n_errors++;
            $display("FAIL o_fmap: expected 0x00, got 0x%02h", o_fmap);
        end
        run_case(0, 1'b0, 1'b0, "full image after mid-image reset");
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        reset_n      = 1'b0;
        i_pix_valid  = 1'b0;
        i_pix        = '0;
        i_cnn_weight = '0;
        i_bias       = '0;
        i_act_mode   = cnn_pkg::ACT_PASS;
        n_out        = 0;
        n_checks     = 0;
        n_errors     = 0;
        check_lat    = 1'b0;
        rng_state    = 32'd79972;
        $readmemh("cnn_conv_patterns.txt", pat_mem);

        run_case(0, 1'b0, 1'b0, "baseline");
        run_case(1, 1'b0, 1'b0, "negative weights with ReLU");
        run_case(1, 1'b1, 1'b0, "negative weights in pass-through");
        run_case(2, 1'b0, 1'b0, "bias saturation");
        run_case(0, 1'b0, 1'b1, "baseline with gaps");
        reset_mid_image();

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== cnn_conv_patterns.txt ====
// Per case: 18 weights (ch0 pos0..8, ch1 pos0..8), bias hi, bias lo, mode (1 = ReLU),
// then 64 pixels in raster order, then 36 expected outputs in raster order
// Case 0: center, top-left and negative bottom-right taps, bias 16, ReLU
00 00 00 00 01 00 00 00 FF 01 00 00 00 00 00 00 00 00 00 10 01
00 01 02 03 04 05 06 07 10 11 12 13 14 15 16 17
20 21 22 23 24 25 26 27 30 31 32 33 34 35 36 37
40 41 42 43 44 45 46 47 50 51 52 53 54 55 56 57
60 61 62 63 64 65 66 67 70 71 72 73 74 75 76 77
00 00 01 02 03 04 0F 10 11 12 13 14
1F 20 21 22 23 24 2F 30 31 32 33 34
3F 40 41 42 43 44 4F 50 51 52 53 54
// Case 1: all channel 0 weights -1, bias 0, ReLU
FF FF FF FF FF FF FF FF FF 00 00 00 00 00 00 00 00 00 00 00 01
00 01 02 03 04 05 06 07 10 11 12 13 14 15 16 17
20 21 22 23 24 25 26 27 30 31 32 33 34 35 36 37
40 41 42 43 44 45 46 47 50 51 52 53 54 55 56 57
60 61 62 63 64 65 66 67 70 71 72 73 74 75 76 77
00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00
// Case 2: case 0 weights, bias 0x1000, pass-through
00 00 00 00 01 00 00 00 FF 01 00 00 00 00 00 00 00 00 10 00 00
00 01 02 03 04 05 06 07 10 11 12 13 14 15 16 17
20 21 22 23 24 25 26 27 30 31 32 33 34 35 36 37
40 41 42 43 44 45 46 47 50 51 52 53 54 55 56 57
60 61 62 63 64 65 66 67 70 71 72 73 74 75 76 77
FF FF FF FF FF FF FF FF FF FF FF FF
FF FF FF FF FF FF FF FF FF FF FF FF
FF FF FF FF FF FF FF FF FF FF FF FF

// ==== filelist.f ====
cnn_pkg.sv
cnn_window_buf.sv
cnn_kernel.sv
cnn_acc_ci.sv
cnn_act_out.sv
cnn_conv_top.sv
tb_cnn_conv.sv

// ==== Makefile ====
# Verilator build and run for the convolution slice testbench

VERILATOR ?= verilator
TOP       ?= tb_cnn_conv
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
FAIL_MSG  ?= Checks failed

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
